// File: shooter_pkg.sv
`default_nettype none

package shooter_pkg;

    // screen coordinate in whole pixels, signed so a missile partly above row 0 stays valid
    typedef logic signed [10:0] pixel_t;

    // vertical position kept in 1/64 pixel steps for smooth sub-pixel motion
    typedef logic signed [31:0] fixed_t;

    // number of fraction bits in fixed_t, so one pixel is 64 fixed units
    localparam int FRAC_BITS = 6;

    // visible screen area in pixels
    localparam int SCREEN_W = 640;
    localparam int SCREEN_H = 480;

    // ship sprite width, the ship height does not matter to the core
    localparam int SHIP_W = 32;

    // missile bounding box
    localparam int MISSILE_W = 4;
    localparam int MISSILE_H = 8;

    // target bounding box
    localparam int TARGET_W = 32;
    localparam int TARGET_H = 16;

    // the missile is either parked waiting for a shot or travelling upward
    typedef enum logic {
        MISSILE_IDLE   = 1'b0,
        MISSILE_FLYING = 1'b1
    } missile_state_t;

endpackage

`default_nettype wire

// File: frame_tick_gen.sv
`default_nettype none

module frame_tick_gen #(
    parameter int FRAME_CYCLES = 16
) (
    input  wire  clk,
    input  wire  resetN,
    output logic start_of_frame
);

    // the counter has to hold FRAME_CYCLES-1, keep at least one bit for tiny frames
    localparam int CNT_W = (FRAME_CYCLES > 1) ? $clog2(FRAME_CYCLES) : 1;
    localparam logic [CNT_W-1:0] RELOAD = CNT_W'(FRAME_CYCLES - 1);

    logic [CNT_W-1:0] cycle_cnt;

    // counts down from RELOAD, the pulse is registered on the edge where zero is seen
    // so the first pulse shows up FRAME_CYCLES clocks after reset is released
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            cycle_cnt      <= RELOAD;
            start_of_frame <= 1'b0;
        end else if (cycle_cnt == '0) begin
            cycle_cnt      <= RELOAD;
            start_of_frame <= 1'b1;
        end else begin
            cycle_cnt      <= cycle_cnt - 1'b1;
            start_of_frame <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: ship_movement.sv
`default_nettype none

module ship_movement
    import shooter_pkg::*;
#(
    parameter int SHIP_STEP    = 3,
    parameter int SHIP_START_X = 304
) (
    input  wire    clk,
    input  wire    resetN,
    input  wire    start_of_frame,
    input  wire    move_left,
    input  wire    move_right,
    output pixel_t ship_x
);

    // rightmost legal left edge so the whole ship stays on screen
    localparam int MAX_X = SCREEN_W - SHIP_W;

    pixel_t next_x;

    // work out the position for the next frame from the current one
    // both keys or no key leaves the ship where it is
    always_comb begin
        next_x = ship_x;
        if (move_left && !move_right) begin
            // clamp at the left screen edge instead of wrapping to negative
            if (ship_x < SHIP_STEP) begin
                next_x = '0;
            end else begin
                next_x = pixel_t'(ship_x - SHIP_STEP);
            end
        end else if (move_right && !move_left) begin
            // clamp so the right edge of the sprite never leaves the screen
            if (ship_x > MAX_X - SHIP_STEP) begin
                next_x = pixel_t'(MAX_X);
            end else begin
                next_x = pixel_t'(ship_x + SHIP_STEP);
            end
        end
    end

    // the position only moves on the frame tick, keys between ticks are ignored
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            ship_x <= pixel_t'(SHIP_START_X);
        end else if (start_of_frame) begin
            ship_x <= next_x;
        end
    end

endmodule

`default_nettype wire

// File: missile_movement.sv
`default_nettype none

module missile_movement
    import shooter_pkg::*;
#(
    parameter int SHIP_Y   = 440,
    parameter int X_OFFSET = 14,
    parameter int Y_SPEED  = -256
) (
    input  wire    clk,
    input  wire    resetN,
    input  wire    start_of_frame,
    input  wire    shot_key,
    input  wire    target_hit,
    input  pixel_t ship_x,
    output pixel_t missile_x,
    output pixel_t missile_y,
    output logic   missile_active
);

    missile_state_t state;
    logic           shot_pending;
    fixed_t         y_fix;
    pixel_t         x_pos;

    // one flight step ahead, used both for the update and for the ceiling test
    fixed_t         y_fix_next;
    pixel_t         y_pix_next;

    assign y_fix_next = y_fix + fixed_t'(Y_SPEED);
    // arithmetic shift gives floor division, so rows above the screen come out negative
    assign y_pix_next = pixel_t'(y_fix_next >>> FRAC_BITS);

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            state        <= MISSILE_IDLE;
            shot_pending <= 1'b0;
            y_fix        <= '0;
            x_pos        <= '0;
        end else begin
            // a shot is only remembered while nothing is in the air
            if (shot_key && state == MISSILE_IDLE) begin
                shot_pending <= 1'b1;
            end
            // a hit wins over the tick and parks the missile at once
            if (target_hit) begin
                state <= MISSILE_IDLE;
            end else if (start_of_frame) begin
                if (state == MISSILE_IDLE) begin
                    if (shot_pending) begin
                        // launch from the ship nose, x stays fixed for the whole flight
                        state        <= MISSILE_FLYING;
                        x_pos        <= pixel_t'(ship_x + X_OFFSET);
                        y_fix        <= fixed_t'(SHIP_Y) <<< FRAC_BITS;
                        shot_pending <= 1'b0;
                    end
                end else begin
                    y_fix <= y_fix_next;
                    // once the bottom edge is at row 0 or above the missile is gone
                    if (y_pix_next + MISSILE_H <= 0) begin
                        state <= MISSILE_IDLE;
                    end
                end
            end
        end
    end

    assign missile_x      = x_pos;
    assign missile_y      = pixel_t'(y_fix >>> FRAC_BITS);
    assign missile_active = (state == MISSILE_FLYING);

    // a shot key during flight is ignored, so nothing can be pending while the missile flies
    a_no_pending_in_flight: assert property (@(posedge clk) disable iff (!resetN)
        missile_active |-> !shot_pending);

    // the hit detector gates on missile_active, so a hit must never reach an idle missile
    a_no_hit_when_idle: assert property (@(posedge clk) disable iff (!resetN)
        (state == MISSILE_IDLE) |-> !target_hit);

    // the frame generator must give one-cycle ticks or the missile would step twice
    a_tick_single: assert property (@(posedge clk) disable iff (!resetN)
        start_of_frame |=> !start_of_frame);

    // a flying missile is always at least partly on screen
    a_flying_on_screen: assert property (@(posedge clk) disable iff (!resetN)
        missile_active |-> (missile_y + MISSILE_H > 0) && (missile_y < SCREEN_H));

endmodule

`default_nettype wire

// File: hit_detector.sv
`default_nettype none

module hit_detector
    import shooter_pkg::*;
(
    input  wire        clk,
    input  wire        resetN,
    input  pixel_t     missile_x,
    input  pixel_t     missile_y,
    input  wire        missile_active,
    input  pixel_t     target_x,
    input  pixel_t     target_y,
    output logic       target_hit,
    output logic [7:0] hit_count
);

    logic overlap_x;
    logic overlap_y;

    // boxes are half open, the left and top edges belong to the box, the right and
    // bottom edges do not, so two boxes that only touch do not overlap
    always_comb begin
        overlap_x = (missile_x < target_x + TARGET_W) &&
                    (missile_x + MISSILE_W > target_x);
        overlap_y = (missile_y < target_y + TARGET_H) &&
                    (missile_y + MISSILE_H > target_y);
    end

    // an idle missile still has a stale position, so it must not report a hit
    assign target_hit = missile_active && overlap_x && overlap_y;

    // counts every hit, wrapping back to 0 after 255
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            hit_count <= '0;
        end else if (target_hit) begin
            hit_count <= hit_count + 8'd1;
        end
    end

    // the missile drops to idle on the same edge the count moves, so the hit cannot linger
    a_hit_one_cycle: assert property (@(posedge clk) disable iff (!resetN)
        target_hit |=> !target_hit);

endmodule

`default_nettype wire

// File: shooter_top.sv
`default_nettype none

module shooter_top
    import shooter_pkg::*;
#(
    parameter int FRAME_CYCLES = 16,
    parameter int SHIP_STEP    = 3,
    parameter int SHIP_START_X = 304,
    parameter int SHIP_Y       = 440,
    parameter int X_OFFSET     = 14,
    parameter int Y_SPEED      = -256
) (
    input  wire        clk,
    input  wire        resetN,
    input  wire        shot_key,
    input  wire        move_left,
    input  wire        move_right,
    input  pixel_t     target_x,
    input  pixel_t     target_y,
    output logic       start_of_frame,
    output pixel_t     ship_x,
    output pixel_t     missile_x,
    output pixel_t     missile_y,
    output logic       missile_active,
    output logic [7:0] hit_count
);

    // combinational hit, fed back so the missile parks on the same edge the count moves
    logic target_hit;

    frame_tick_gen #(
        .FRAME_CYCLES (FRAME_CYCLES)
    ) u_frame_tick_gen (
        .clk            (clk),
        .resetN         (resetN),
        .start_of_frame (start_of_frame)
    );

    ship_movement #(
        .SHIP_STEP    (SHIP_STEP),
        .SHIP_START_X (SHIP_START_X)
    ) u_ship_movement (
        .clk            (clk),
        .resetN         (resetN),
        .start_of_frame (start_of_frame),
        .move_left      (move_left),
        .move_right     (move_right),
        .ship_x         (ship_x)
    );

    missile_movement #(
        .SHIP_Y   (SHIP_Y),
        .X_OFFSET (X_OFFSET),
        .Y_SPEED  (Y_SPEED)
    ) u_missile_movement (
        .clk            (clk),
        .resetN         (resetN),
        .start_of_frame (start_of_frame),
        .shot_key       (shot_key),
        .target_hit     (target_hit),
        .ship_x         (ship_x),
        .missile_x      (missile_x),
        .missile_y      (missile_y),
        .missile_active (missile_active)
    );

    hit_detector u_hit_detector (
        .clk            (clk),
        .resetN         (resetN),
        .missile_x      (missile_x),
        .missile_y      (missile_y),
        .missile_active (missile_active),
        .target_x       (target_x),
        .target_y       (target_y),
        .target_hit     (target_hit),
        .hit_count      (hit_count)
    );

endmodule

`default_nettype wire

// File: shooter_checker.sv
`default_nettype none

module shooter_checker
    import shooter_pkg::*;
#(
    parameter int FRAME_CYCLES = 16,
    parameter int SHIP_STEP    = 3,
    parameter int SHIP_START_X = 304,
    parameter int SHIP_Y       = 440,
    parameter int X_OFFSET     = 14,
    parameter int Y_SPEED      = -256
) (
    input  wire        clk,
    input  wire        resetN,
    input  wire        shot_key,
    input  wire        move_left,
    input  wire        move_right,
    input  pixel_t     target_x,
    input  pixel_t     target_y,
    input  wire        start_of_frame,
    input  pixel_t     ship_x,
    input  pixel_t     missile_x,
    input  pixel_t     missile_y,
    input  wire        missile_active,
    input  wire [7:0]  hit_count,
    output int         error_count,
    output int         check_count
);
    timeunit 1ns;
    timeprecision 100ps;

    int errors = 0;
    int checks = 0;

    // reference model state, it always holds the values the DUT shows this cycle
    int             edge_count;
    logic           exp_sof;
    int             exp_ship;
    logic           pending;
    missile_state_t exp_state;
    int             exp_y_fix;
    int             exp_mx;
    int             exp_count;

    assign error_count = errors;
    assign check_count = checks;

    // floor division by one pixel, negative values round toward minus infinity
    function automatic int fixed_to_pixel(input int fix);
        int unit;
        int q;
        unit = 1 << FRAC_BITS;
        q = fix / unit;
        if (fix < 0 && (fix % unit) != 0) begin
            q = q - 1;
        end
        return q;
    endfunction

    // half open boxes, touching edges are no overlap
    function automatic logic boxes_overlap(input int mx, input int my, input int tx, input int ty);
        return (mx < tx + TARGET_W) && (mx + MISSILE_W > tx) &&
               (my < ty + TARGET_H) && (my + MISSILE_H > ty);
    endfunction

    task automatic compare(input string name, input int expected, input int actual);
        checks = checks + 1;
        if (expected != actual) begin
            errors = errors + 1;
            $display("** Error [%s] at %0t ns: expected %0d, actual %0d",
                     name, $time, expected, actual);
        end
    endtask

    task automatic reset_model();
        edge_count = 0;
        exp_sof    = 1'b0;
        exp_ship   = SHIP_START_X;
        pending    = 1'b0;
        exp_state  = MISSILE_IDLE;
        exp_y_fix  = 0;
        exp_mx     = 0;
        exp_count  = 0;
    endtask

    task automatic check_reset_values();
        compare("reset_values", 0, int'(start_of_frame));
        compare("reset_values", SHIP_START_X, int'(ship_x));
        compare("reset_values", 0, int'(missile_x));
        compare("reset_values", 0, int'(missile_y));
        compare("reset_values", 0, int'(missile_active));
        compare("reset_values", 0, int'(hit_count));
    endtask

    task automatic check_outputs();
        compare("frame_tick", int'(exp_sof), int'(start_of_frame));
        compare("ship_motion", exp_ship, int'(ship_x));
        compare("launch_x", exp_mx, int'(missile_x));
        compare("flight_y", fixed_to_pixel(exp_y_fix), int'(missile_y));
        compare("missile_active", int'(exp_state == MISSILE_FLYING), int'(missile_active));
        compare("hit_count", exp_count, int'(hit_count));
    endtask

    // predicts the state after the next rising edge from the inputs held right now
    task automatic advance_model();
        int   next_ship;
        logic hit;
        logic was_pending;
        next_ship = exp_ship;
        hit = (exp_state == MISSILE_FLYING) &&
              boxes_overlap(exp_mx, fixed_to_pixel(exp_y_fix), int'(target_x), int'(target_y));
        if (exp_sof) begin
            if (move_left && !move_right) begin
                next_ship = exp_ship - SHIP_STEP;
            end else if (move_right && !move_left) begin
                next_ship = exp_ship + SHIP_STEP;
            end
            if (next_ship < 0) begin
                next_ship = 0;
            end
            if (next_ship > SCREEN_W - SHIP_W) begin
                next_ship = SCREEN_W - SHIP_W;
            end
        end
        // a shot seen on this edge can only launch on a later tick
        was_pending = pending;
        if (shot_key && exp_state == MISSILE_IDLE) begin
            pending = 1'b1;
        end
        // a hit wins over the tick
        if (hit) begin
            exp_state = MISSILE_IDLE;
            exp_count = (exp_count + 1) % 256;
        end else if (exp_sof) begin
            if (exp_state == MISSILE_IDLE && was_pending) begin
                exp_state = MISSILE_FLYING;
                exp_mx    = exp_ship + X_OFFSET;
                exp_y_fix = SHIP_Y * (1 << FRAC_BITS);
                pending   = 1'b0;
            end else if (exp_state == MISSILE_FLYING) begin
                exp_y_fix = exp_y_fix + Y_SPEED;
                // the bottom edge at row 0 or above means the missile left the screen
                if (fixed_to_pixel(exp_y_fix) + MISSILE_H <= 0) begin
                    exp_state = MISSILE_IDLE;
                end
            end
        end
        exp_ship   = next_ship;
        edge_count = edge_count + 1;
        exp_sof    = (edge_count % FRAME_CYCLES) == 0;
    endtask

    // the falling edge sits between stimulus updates, so outputs and inputs are both settled
    always @(negedge clk) begin
        if (!resetN) begin
            check_reset_values();
            reset_model();
        end else begin
            check_outputs();
            advance_model();
        end
    end

endmodule

`default_nettype wire

// File: tb_shooter.sv
`default_nettype none

module tb_shooter
    import shooter_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int FRAME_CYCLES = 16;
    localparam int NUM_FRAMES   = 600;
    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 5;
    localparam int TARGET_HOLD  = 200;
    // held key phases at the start, long enough to push the ship into both clamps
    localparam int LEFT_FRAMES  = 120;
    localparam int RIGHT_FRAMES = 220;
    // twice the nominal run length
    localparam int WATCHDOG_NS  = 2 * NUM_FRAMES * FRAME_CYCLES * CLK_PERIOD;

    logic       clk;
    logic       resetN;
    logic       shot_key;
    logic       move_left;
    logic       move_right;
    pixel_t     target_x;
    pixel_t     target_y;
    logic       start_of_frame;
    pixel_t     ship_x;
    pixel_t     missile_x;
    pixel_t     missile_y;
    logic       missile_active;
    logic [7:0] hit_count;
    int         error_count;
    int         check_count;
    int         seed;
    int         frame_count;

    shooter_top #(
        .FRAME_CYCLES (FRAME_CYCLES)
    ) dut (
        .clk            (clk),
        .resetN         (resetN),
        .shot_key       (shot_key),
        .move_left      (move_left),
        .move_right     (move_right),
        .target_x       (target_x),
        .target_y       (target_y),
        .start_of_frame (start_of_frame),
        .ship_x         (ship_x),
        .missile_x      (missile_x),
        .missile_y      (missile_y),
        .missile_active (missile_active),
        .hit_count      (hit_count)
    );

    shooter_checker #(
        .FRAME_CYCLES (FRAME_CYCLES)
    ) u_checker (
        .clk            (clk),
        .resetN         (resetN),
        .shot_key       (shot_key),
        .move_left      (move_left),
        .move_right     (move_right),
        .target_x       (target_x),
        .target_y       (target_y),
        .start_of_frame (start_of_frame),
        .ship_x         (ship_x),
        .missile_x      (missile_x),
        .missile_y      (missile_y),
        .missile_active (missile_active),
        .hit_count      (hit_count),
        .error_count    (error_count),
        .check_count    (check_count)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // target anywhere across the screen width, rows 40 to 400
    task automatic move_target();
        target_x = pixel_t'($unsigned($random(seed)) % (SCREEN_W - TARGET_W + 1));
        target_y = pixel_t'(40 + $unsigned($random(seed)) % 361);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns before all frames were run", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        seed       = 32'hc1cf;
        clk        = 1'b0;
        resetN     = 1'b1;
        shot_key   = 1'b0;
        move_left  = 1'b0;
        move_right = 1'b0;
        move_target();
        // a real falling edge so the asynchronous reset acts at once
        #2 resetN = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2 resetN = 1'b1;
        frame_count = 0;
        while (frame_count < NUM_FRAMES) begin
            @(posedge clk);
            #2;
            if (start_of_frame) begin
                frame_count = frame_count + 1;
                if (frame_count % TARGET_HOLD == 0) begin
                    move_target();
                end
                if (frame_count <= LEFT_FRAMES) begin
                    // walk the ship all the way into the left edge
                    move_left  = 1'b1;
                    move_right = 1'b0;
                end else if (frame_count <= LEFT_FRAMES + RIGHT_FRAMES) begin
                    // then across the whole screen into the right edge
                    move_left  = 1'b0;
                    move_right = 1'b1;
                end else begin
                    // each key flips with even odds once per frame
                    if ($random(seed) & 1) begin
                        move_left = ~move_left;
                    end
                    if ($random(seed) & 1) begin
                        move_right = ~move_right;
                    end
                end
            end
            shot_key = ($random(seed) & 7) == 0;
        end
        // let the checker see the last edges
        repeat (2) @(negedge clk);
        #1;
        $display("frames: %0d, checks: %0d, errors: %0d, hits: %0d",
                 frame_count, check_count, error_count, hit_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
shooter_pkg.sv
frame_tick_gen.sv
ship_movement.sv
missile_movement.sv
hit_detector.sv
shooter_top.sv
shooter_checker.sv
tb_shooter.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = tb_shooter
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
PASS_MSG  = Simulation completed successfully

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
